// File: hw/sensor_phase_pkg.sv
package sensor_phase_pkg;

  // bus widths
  localparam int RAW_W   = 12;  // sensor data pads
  localparam int PIX_W   = 14;  // packed pixel out
  localparam int LINE_W  = 14;  // line length counter
  localparam int PHASE_W = 3;   // sync phase, whole clock cycles
  localparam int CMD_W   = 6;

  // command word bits for the sync phase
  localparam int CMD_BIT_PHASE_UP = 4;
  localparam int CMD_BIT_PHASE_DN = 5;  // both up and dn together reset phase to 0

  localparam int SYNC_TAPS   = 8;  // one tap per phase value
  localparam int PIX_LATENCY = 8;  // pads to o_pixel, cycles

  // pixel delay stages after the input sample and pack registers
  localparam int PIX_PIPE_DEPTH = PIX_LATENCY - 2;

  typedef logic [RAW_W-1:0]   raw_pixel_t;
  typedef logic [PIX_W-1:0]   pixel_t;
  typedef logic [LINE_W-1:0]  line_len_t;
  typedef logic [PHASE_W-1:0] sync_phase_t;
  typedef logic [CMD_W-1:0]   sensor_cmd_t;

  // frame/line sync pair, pads through to the output stage
  typedef struct packed {
    logic vact;
    logic hact;
  } sync_t;

  // bit mode select, both low means 10 bit
  typedef struct packed {
    logic mode_12;  // 12 bit (also set together with mode_14 is fine)
    logic mode_14;  // 14 bit, low two bits from vact/hact pins
  } pixel_mode_t;

endpackage

// File: hw/sync_phase_adjust.sv
`timescale 1ns/1ps

module sync_phase_adjust
  import sensor_phase_pkg::*;
(
  input  logic        gclk_idata,
  input  logic        reset_rq,
  input  logic        i_wcmd,   // strobe for i_cmd
  input  sensor_cmd_t i_cmd,
  input  sync_t       i_sync,   // hact/vact straight from the pads
  output sync_t       o_sync    // delayed by 2 + phase
);

  sync_phase_t phase;                 // current sync delay vs data
  sync_t       sync_dl [SYNC_TAPS];   // [0] is the registered pad sync
  logic        cmd_up;
  logic        cmd_dn;

  assign cmd_up = i_wcmd && i_cmd[CMD_BIT_PHASE_UP];
  assign cmd_dn = i_wcmd && i_cmd[CMD_BIT_PHASE_DN];

  // phase register, wraps modulo 8
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      phase <= '0;
    end else if (cmd_up && cmd_dn) begin
      phase <= '0;                            // reset command
    end else if (cmd_up) begin
      phase <= phase + sync_phase_t'(1);      // sync later
    end else if (cmd_dn) begin
      phase <= phase - sync_phase_t'(1);      // sync earlier
    end
  end

  // tapped delay line, tap k is k+1 cycles behind the pads
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      sync_dl <= '{default: '0};
    end else begin
      sync_dl[0] <= i_sync;
      for (int i = 1; i < SYNC_TAPS; i++) begin
        sync_dl[i] <= sync_dl[i-1];
      end
    end
  end

  // pick the tap, one more register so phase 0 means 2 cycles
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      o_sync <= '0;
    end else begin
      o_sync <= sync_dl[phase];  // new phase takes effect right after the command
    end
  end

endmodule

// File: hw/alt_sync_decoder.sv
`timescale 1ns/1ps

module alt_sync_decoder
  import sensor_phase_pkg::*;
(
  input  logic  gclk_idata,
  input  logic  reset_rq,
  input  logic  i_mode_alt,   // 1 - take sync from the combined pad
  input  logic  i_sync_alt,   // combined pad: 1 cycle = vact, longer = hact
  input  sync_t i_sync,       // phased sensor sync
  output sync_t o_sync
);

  logic [2:0] alt_hist;  // [0] newest pad sample, [1] the one being decoded
  logic       alt_hact;
  logic       alt_vact;

  // middle sample with any high neighbour belongs to a run
  assign alt_hact = alt_hist[1] && (alt_hist[0] || alt_hist[2]);
  // isolated single cycle
  assign alt_vact = alt_hist[1] && !alt_hist[0] && !alt_hist[2];

  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      alt_hist <= '0;
    end else begin
      alt_hist <= {alt_hist[1:0], i_sync_alt & i_mode_alt};  // idle when alt mode is off
    end
  end

  // select and register, one cycle in sensor mode
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      o_sync <= '0;
    end else if (i_mode_alt) begin
      o_sync.vact <= alt_vact;
      o_sync.hact <= alt_hact;
    end else begin
      o_sync <= i_sync;
    end
  end

endmodule

// File: hw/pixel_packer.sv
`timescale 1ns/1ps

module pixel_packer
  import sensor_phase_pkg::*;
(
  input  logic        gclk_idata,
  input  logic        reset_rq,
  input  pixel_mode_t i_mode,   // static while streaming
  input  raw_pixel_t  i_di,     // sensor data pads
  input  sync_t       i_sync,   // pad sync, not phased
  output pixel_t      o_pixel
);

  raw_pixel_t di_q;                     // pad sample
  sync_t      sync_q;                   // pad vact/hact, same cycle as di_q
  pixel_t     pix_pack;
  pixel_t     pix_dl [PIX_PIPE_DEPTH];  // latency padding up to PIX_LATENCY
  logic [1:0] pix_mid;                  // bits 3:2
  logic [1:0] pix_low;                  // bits 1:0

  // 12/14 bit keep the two low data bits, else zero
  assign pix_mid = (i_mode.mode_12 || i_mode.mode_14) ? di_q[1:0] : 2'b00;
  // 14 bit mode borrows the sync pins as extra data
  assign pix_low = i_mode.mode_14 ? {sync_q.vact, sync_q.hact} : 2'b00;

  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      di_q     <= '0;
      sync_q   <= '0;
      pix_pack <= '0;
    end else begin
      di_q     <= i_di;
      sync_q   <= i_sync;
      pix_pack <= {di_q[RAW_W-1:2], pix_mid, pix_low};  // upper ten bits on top
    end
  end

  // o_pixel is zero until real data reaches the end
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      pix_dl <= '{default: '0};
    end else begin
      pix_dl[0] <= pix_pack;
      for (int i = 1; i < PIX_PIPE_DEPTH; i++) begin
        pix_dl[i] <= pix_dl[i-1];
      end
    end
  end

  assign o_pixel = pix_dl[PIX_PIPE_DEPTH-1];

endmodule

// File: hw/sync_output_stage.sv
`timescale 1ns/1ps

module sync_output_stage
  import sensor_phase_pkg::*;
(
  input  logic      gclk_idata,
  input  logic      reset_rq,
  input  sync_t     i_sync,         // selected sync, phased or alt
  input  logic      i_pad_hact,     // raw pad hact, used for the regen latch only
  input  logic      i_hact_regen,   // 1 - line length from i_hact_length
  input  line_len_t i_hact_length,  // pixels per line
  output logic      o_shact,
  output logic      o_svact,        // frame start pulse
  output logic      o_fvact         // frame end pulse
);

  logic       regen_q;      // regen mode, changed only between lines
  logic [1:0] hact_run;     // hact history, only counts when regenerating
  logic       hact_mark;    // full hact, or 2-cycle start mark in regen mode
  logic       hact_mark_q;
  logic       hact_start;
  logic       hact_stop;
  line_len_t  hact_cnt;     // cycles left in the current line
  logic       vact_q;
  logic       vact_qq;

  // regen mode latch, both pad and output hact must be low so no short line
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      regen_q <= 1'b0;
    end else if (!i_pad_hact && !o_shact) begin
      regen_q <= i_hact_regen;
    end
  end

  // with regen off hact_run stays 0 and the mark copies hact
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      hact_run    <= '0;
      hact_mark   <= 1'b0;
      hact_mark_q <= 1'b0;
    end else begin
      hact_run    <= {hact_run[0], i_sync.hact && regen_q};
      hact_mark   <= (i_sync.hact && !hact_run[0]) ||  // first cycle
                     (hact_run[0] && !hact_run[1]);    // second cycle
      hact_mark_q <= hact_mark;
    end
  end

  assign hact_start = hact_mark && !hact_mark_q;
  // counted length in regen mode, else follow the mark
  assign hact_stop  = regen_q ? (hact_cnt == line_len_t'(1)) : !hact_mark;

  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      o_shact <= 1'b0;
    end else if (hact_start) begin
      o_shact <= 1'b1;
    end else if (hact_stop) begin
      o_shact <= 1'b0;
    end
  end

  // preload while idle, count down over the line
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      hact_cnt <= '0;
    end else if (!o_shact) begin
      hact_cnt <= i_hact_length;
    end else begin
      hact_cnt <= hact_cnt - line_len_t'(1);
    end
  end

  // vact edges, two cycles after the input edge
  always_ff @(posedge gclk_idata or posedge reset_rq) begin
    if (reset_rq) begin
      vact_q  <= 1'b0;
      vact_qq <= 1'b0;
      o_svact <= 1'b0;
      o_fvact <= 1'b0;
    end else begin
      vact_q  <= i_sync.vact;
      vact_qq <= vact_q;
      o_svact <= vact_q && !vact_qq;  // rise
      o_fvact <= !vact_q && vact_qq;  // fall
    end
  end

endmodule

// File: hw/sensor_phase_top.sv
`timescale 1ns/1ps

module sensor_phase_top
  import sensor_phase_pkg::*;
(
  input  logic        gclk_idata,
  input  logic        reset_rq,
  input  logic        i_wcmd,
  input  sensor_cmd_t i_cmd,
  input  logic        i_hact,
  input  logic        i_vact,
  input  raw_pixel_t  i_di,
  input  logic        i_sync_alt,
  input  logic        i_mode_alt,
  input  pixel_mode_t i_mode,
  input  logic        i_hact_regen,
  input  line_len_t   i_hact_length,
  output pixel_t      o_pixel,
  output logic        o_shact,
  output logic        o_svact,
  output logic        o_fvact
);

  sync_t pad_sync;     // straight from the pins
  sync_t phased_sync;  // after the phase delay
  sync_t sel_sync;     // phased or alt pad

  assign pad_sync.vact = i_vact;
  assign pad_sync.hact = i_hact;

  sync_phase_adjust u_phase (
    .gclk_idata (gclk_idata),
    .reset_rq   (reset_rq),
    .i_wcmd     (i_wcmd),
    .i_cmd      (i_cmd),
    .i_sync     (pad_sync),
    .o_sync     (phased_sync)
  );

  alt_sync_decoder u_alt (
    .gclk_idata (gclk_idata),
    .reset_rq   (reset_rq),
    .i_mode_alt (i_mode_alt),
    .i_sync_alt (i_sync_alt),
    .i_sync     (phased_sync),
    .o_sync     (sel_sync)
  );

  pixel_packer u_pack (
    .gclk_idata (gclk_idata),
    .reset_rq   (reset_rq),
    .i_mode     (i_mode),
    .i_di       (i_di),
    .i_sync     (pad_sync),  // low bits use the unphased pins
    .o_pixel    (o_pixel)
  );

  sync_output_stage u_out (
    .gclk_idata    (gclk_idata),
    .reset_rq      (reset_rq),
    .i_sync        (sel_sync),
    .i_pad_hact    (i_hact),
    .i_hact_regen  (i_hact_regen),
    .i_hact_length (i_hact_length),
    .o_shact       (o_shact),
    .o_svact       (o_svact),
    .o_fvact       (o_fvact)
  );

endmodule

// File: include/sensor_phase_tb_checks.svh
`ifndef SENSOR_PHASE_TB_CHECKS_SVH
`define SENSOR_PHASE_TB_CHECKS_SVH

// 32-bit xorshift step, state must never be zero
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

// expected packed pixel for one pad sample
function automatic pixel_t ref_pack(input raw_pixel_t di, input sync_t s, input pixel_mode_t m);
  pixel_t p;
  p = '0;
  p[13:4] = di[11:2];                 // upper ten bits always
  if (m.mode_12 || m.mode_14) begin
    p[3:2] = di[1:0];
  end
  if (m.mode_14) begin
    p[1:0] = {s.vact, s.hact};        // sync pins as data
  end
  return p;
endfunction

// stop on the first wrong pixel
task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("Verification failed");
    $fatal(1);
  end
endtask

// single bit version, for the sync outputs
task automatic compare_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    $display("Verification failed");
    $fatal(1);
  end
endtask

`endif

// File: dv/sensor_phase_tb.sv
`timescale 1ns/1ps

module sensor_phase_tb
  import sensor_phase_pkg::*;
();

  `include "sensor_phase_tb_checks.svh"

  localparam int SYNC_BASE_LATENCY = 5;  // sync pad edge to output edge at phase 0
  localparam int WAIT_LIMIT        = 200;

  logic        gclk_idata = 1'b0;
  logic        reset_rq   = 1'b1;
  logic        i_wcmd     = 1'b0;
  sensor_cmd_t i_cmd      = '0;
  logic        i_hact     = 1'b0;
  logic        i_vact     = 1'b0;
  raw_pixel_t  i_di       = '0;
  logic        i_sync_alt = 1'b0;
  logic        i_mode_alt = 1'b0;
  pixel_mode_t i_mode     = '0;
  logic        i_hact_regen  = 1'b0;
  line_len_t   i_hact_length = line_len_t'(16);
  pixel_t      o_pixel;
  logic        o_shact;
  logic        o_svact;
  logic        o_fvact;

  logic [31:0] rng = 32'h33b4;
  sync_phase_t model_phase = '0;  // phase the DUT should hold
  logic        model_regen = 1'b0;
  logic        mon_en      = 1'b0;
  logic        check_sync  = 1'b1;  // off in alt mode, counts only
  logic        alt_count   = 1'b0;
  int          cyc = 64;            // history index, starts high so cyc-d stays positive
  logic        hist_h [64];
  logic        hist_v [64];
  pixel_t      exp_q [$];           // expected pixels, PIX_LATENCY deep
  int          remaining = 0;       // regen model, cycles left in the line
  logic        shact_prev = 1'b0;
  pixel_t      rise_pix;
  logic        rise_seen = 1'b0;
  int          svact_cnt = 0;
  int          run_len = 0;
  int          widths [$];          // o_shact high widths in alt mode

  sensor_phase_top uut (.*);

  always #20 gclk_idata = ~gclk_idata;

  task automatic fail_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Verification failed");
    $fatal(1);
  endtask

  // counts from the alt mode checks
  task automatic compare_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
      fail_run("count check on the alt sync path");
    end
  endtask

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic drive(input logic h, input logic v, input raw_pixel_t d);
    @(posedge gclk_idata);
    i_hact <= h;
    i_vact <= v;
    i_di   <= d;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++) drive(1'b0, 1'b0, '0);
  endtask

  // one line of random pixels, vact held at the given level
  task automatic send_line(input int width, input logic v);
    for (int i = 0; i < width; i++) drive(1'b1, v, raw_pixel_t'(next_rand()));
  endtask

  task automatic send_frame(input int width);
    drive(1'b0, 1'b1, '0);
    repeat (3) drive(1'b0, 1'b1, '0);
    send_line(width, 1'b1);
    repeat (3) drive(1'b0, 1'b1, '0);
    idle(20);  // vact fall and pipeline drain
  endtask

  task automatic issue_cmd(input logic up, input logic dn);
    sensor_cmd_t c;
    c = sensor_cmd_t'(next_rand());  // unused bits random
    c[CMD_BIT_PHASE_UP] = up;
    c[CMD_BIT_PHASE_DN] = dn;
    @(posedge gclk_idata);
    i_wcmd <= 1'b1;
    i_cmd  <= c;
    @(posedge gclk_idata);
    i_wcmd <= 1'b0;
    if (up && dn) model_phase = '0;
    else if (up) model_phase = model_phase + sync_phase_t'(1);
    else if (dn) model_phase = model_phase - sync_phase_t'(1);
    idle(20);
  endtask

  task automatic set_mode(input logic m12, input logic m14);
    idle(4);
    @(posedge gclk_idata);
    i_mode <= '{mode_12: m12, mode_14: m14};
    idle(4);
  endtask

  // pixel path always checked, sync rules only outside alt mode
  always @(negedge gclk_idata) begin
    int     d;
    logic   eh;
    logic   ehp;
    logic   ev;
    logic   evp;
    logic   exp_sh;
    pixel_t exp_p;
    if (mon_en) begin
      cyc++;
      hist_h[cyc & 63] = i_hact;
      hist_v[cyc & 63] = i_vact;
      exp_q.push_back(ref_pack(i_di, '{vact: i_vact, hact: i_hact}, i_mode));
      exp_p = exp_q.pop_front();
      compare_pixel("o_pixel", o_pixel, exp_p);
      if (o_shact && !shact_prev) begin
        rise_pix  = o_pixel;
        rise_seen = 1'b1;
      end
      shact_prev = o_shact;
      if (check_sync) begin
        d   = SYNC_BASE_LATENCY + int'(model_phase);
        eh  = hist_h[(cyc - d) & 63];
        ehp = hist_h[(cyc - d - 1) & 63];
        ev  = hist_v[(cyc - d) & 63];
        evp = hist_v[(cyc - d - 1) & 63];
        if (model_regen) begin
          if (eh && !ehp) remaining = int'(i_hact_length);  // counted line
          exp_sh = (remaining > 0);
          if (remaining > 0) remaining--;
        end else begin
          exp_sh = eh;
        end
        compare_bit("o_shact", o_shact, exp_sh);
        compare_bit("o_svact", o_svact, ev && !evp);
        compare_bit("o_fvact", o_fvact, !ev && evp);
      end
      if (alt_count) begin
        if (o_svact) svact_cnt++;
        if (o_shact) begin
          run_len++;
        end else if (run_len > 0) begin
          widths.push_back(run_len);
          run_len = 0;
        end
      end
    end
  end

  initial begin
    int n;
    int len;
    int t;
    pixel_t first_pix;
    for (int i = 0; i < 64; i++) begin
      hist_h[i] = 1'b0;
      hist_v[i] = 1'b0;
    end
    for (int i = 0; i < PIX_LATENCY; i++) exp_q.push_back('0);
    repeat (10) @(posedge gclk_idata);
    reset_rq <= 1'b0;
    @(posedge gclk_idata);
    mon_en = 1'b1;
    idle(10);

    // pixel modes 10, 12, 14
    set_mode(1'b0, 1'b0);
    for (int i = 0; i < 30; i++) drive(1'b0, 1'b0, raw_pixel_t'(next_rand()));
    set_mode(1'b1, 1'b0);
    for (int i = 0; i < 30; i++) drive(1'b0, 1'b0, raw_pixel_t'(next_rand()));
    set_mode(1'b0, 1'b1);
    for (int i = 0; i < 40; i++) begin
      n = int'(next_rand());
      drive(n[0], n[1], raw_pixel_t'(n >> 8));  // sync pins as data bits
    end
    idle(20);

    // phase steps, wrap past 7 and the reset command
    repeat (3) issue_cmd(1'b1, 1'b0);
    send_frame(3 + int'(next_rand() % 18));
    repeat (5) issue_cmd(1'b1, 1'b0);
    send_frame(3 + int'(next_rand() % 18));
    issue_cmd(1'b0, 1'b1);
    send_frame(3 + int'(next_rand() % 18));
    issue_cmd(1'b1, 1'b1);
    send_frame(3 + int'(next_rand() % 18));
    repeat (3) issue_cmd(1'b1, 1'b0);

    // phase 3, first pixel lines up with the o_shact rise
    rise_seen = 1'b0;
    first_pix = '0;
    @(posedge gclk_idata);
    i_hact <= 1'b1;
    i_vact <= 1'b0;
    i_di   <= raw_pixel_t'(next_rand());
    @(negedge gclk_idata);
    first_pix = ref_pack(i_di, '{vact: 1'b0, hact: 1'b1}, i_mode);
    send_line(10, 1'b0);
    t = 0;
    while (!rise_seen) begin
      drive(1'b0, 1'b0, '0);
      t++;
      if (t > WAIT_LIMIT) fail_run("no o_shact rise after the phase 3 line");
    end
    compare_pixel("o_pixel at o_shact rise", rise_pix, first_pix);
    idle(20);

    // regenerated hact, random lengths and input widths
    @(posedge gclk_idata);
    i_hact_regen <= 1'b1;
    model_regen = 1'b1;
    idle(30);
    for (int k = 0; k < 6; k++) begin
      len = 3 + int'(next_rand() % 38);
      @(posedge gclk_idata);
      i_hact_length <= line_len_t'(len);
      idle(2);
      send_line(1 + int'(next_rand() % 30), 1'b0);
      idle(len + 15);
    end
    @(posedge gclk_idata);
    i_hact_regen <= 1'b0;
    model_regen = 1'b0;
    idle(30);

    // alt sync pad
    check_sync = 1'b0;
    @(posedge gclk_idata);
    i_mode_alt <= 1'b1;
    idle(10);
    alt_count = 1'b1;
    @(posedge gclk_idata);
    i_sync_alt <= 1'b1;
    @(posedge gclk_idata);
    i_sync_alt <= 1'b0;
    t = 0;
    while (svact_cnt < 1) begin
      idle(1);
      t++;
      if (t > WAIT_LIMIT) fail_run("no o_svact pulse for a one cycle alt sync pulse");
    end
    idle(15);
    compare_count("o_svact pulses", svact_cnt, 1);
    compare_count("o_shact lines after vact pulse", widths.size(), 0);
    for (int k = 0; k < 5; k++) begin
      n = 2 + int'(next_rand() % 20);
      for (int i = 0; i < n; i++) begin
        @(posedge gclk_idata);
        i_sync_alt <= 1'b1;
      end
      @(posedge gclk_idata);
      i_sync_alt <= 1'b0;
      t = 0;
      while (widths.size() == 0) begin
        idle(1);
        t++;
        if (t > WAIT_LIMIT) fail_run("o_shact did not end after an alt sync run");
      end
      compare_count("o_shact width", widths.pop_front(), n);
      idle(6);
    end
    compare_count("o_svact pulses after runs", svact_cnt, 1);

    $display("Verification passed");
    $finish;
  end

  // overall limit in case some loop never ends
  initial begin
    #2_000_000;
    fail_run("simulation timeout");
  end

endmodule

// File: sim.f
+incdir+include
hw/sensor_phase_pkg.sv
hw/sync_phase_adjust.sv
hw/alt_sync_decoder.sv
hw/pixel_packer.sv
hw/sync_output_stage.sv
hw/sensor_phase_top.sv
dv/sensor_phase_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= sensor_phase_tb
RTL_TOP   ?= sensor_phase_top
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_STR  ?= Verification passed

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FLIST) hw/*.sv dv/*.sv include/*.svh
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(PASS_STR)" $(LOG); then \
	  echo "simulation run OK"; \
	else \
	  echo "simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only hw/sensor_phase_pkg.sv hw/sync_phase_adjust.sv \
	  hw/alt_sync_decoder.sv hw/pixel_packer.sv hw/sync_output_stage.sv \
	  hw/sensor_phase_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
